//--- Bender.yml
package:
  name: instr_fetch

sources:
  - include_dirs:
      - include
    files:
      - logic/fetch_pkg.sv
      - logic/pc_generator.sv
      - logic/branch_predictor.sv
      - logic/instr_queue.sv
      - logic/instr_fetch.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_instr_fetch.sv

//--- filelist.f
+incdir+include
logic/fetch_pkg.sv
logic/pc_generator.sv
logic/branch_predictor.sv
logic/instr_queue.sv
logic/instr_fetch.sv
testbench/tb_instr_fetch.sv

//--- include/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// instructions per aligned fetch block
// a power of two, at least 2
`define FETCH_NUM 2

// program counter after reset
`define BOOT_VEC 32'hbfc00000

// branch target buffer entries
// a power of two, at least 2
`define BTB_SIZE_DEF 8

// instruction queue entries
`define QUEUE_DEPTH_DEF 4

`endif

//--- logic/branch_predictor.sv
`timescale 1ns/100ps
`include "fetch_params.svh"

module branch_predictor #(
	parameter int BTB_SIZE = `BTB_SIZE_DEF
)(
	input  logic                                            clk,
	input  logic                                            rst,
	input  fetch_pkg::virt_t                                block_vaddr,
	input  logic                      [`FETCH_NUM-1:0]      slot_valid,
	input  fetch_pkg::branch_resolved_t                     resolved,
	output fetch_pkg::branch_predict_t [`FETCH_NUM-1:0]     predict,
	output logic                                            predict_valid,
	output fetch_pkg::virt_t                                predict_vaddr,
	output logic                      [`FETCH_NUM-1:0]      taken_mask
);

	import fetch_pkg::*;

	localparam int IDX_W = $clog2(BTB_SIZE);
	localparam int TAG_W = 32 - IDX_W - 2;

	typedef logic [IDX_W-1:0] btb_idx_t;
	typedef logic [TAG_W-1:0] btb_tag_t;

	logic     [BTB_SIZE-1:0] btb_valid;
	btb_tag_t                btb_tag    [BTB_SIZE];
	virt_t                   btb_target [BTB_SIZE];

	virt_t    [`FETCH_NUM-1:0] slot_vaddr;
	btb_idx_t [`FETCH_NUM-1:0] slot_idx;
	logic     [`FETCH_NUM-1:0] hit;

	logic     bp_write;
	btb_idx_t wr_idx;

	// lookup per slot of the stage 2 block
	for (genvar i = 0; i < `FETCH_NUM; i++) begin : gen_lookup
		assign slot_vaddr[i] = block_vaddr + virt_t'(4 * i);
		assign slot_idx[i]   = slot_vaddr[i][IDX_W+1:2];
		assign hit[i]        = slot_valid[i] & btb_valid[slot_idx[i]]
			& (btb_tag[slot_idx[i]] == slot_vaddr[i][31:IDX_W+2]);
	end

	// only the first hit counts, later slots are on the wrong path
	always_comb begin
		logic found;
		found         = 1'b0;
		predict_valid = 1'b0;
		predict_vaddr = '0;
		for (int i = 0; i < `FETCH_NUM; i++) begin
			taken_mask[i]     = ~found;
			predict[i].taken  = hit[i] & ~found;
			// fall-through address when not taken
			predict[i].target = slot_vaddr[i] + virt_t'(4);
			if (hit[i] && !found) begin
				found             = 1'b1;
				predict_valid     = 1'b1;
				predict_vaddr     = btb_target[slot_idx[i]];
				predict[i].target = btb_target[slot_idx[i]];
			end
		end
	end

	// train on mispredicts only
	assign bp_write = resolved.valid & resolved.mispredict;
	assign wr_idx   = resolved.pc[IDX_W+1:2];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			btb_valid <= '0;
		end else if (bp_write) begin
			btb_valid[wr_idx] <= resolved.taken;
		end
	end

	always_ff @(posedge clk) begin
		if (bp_write && resolved.taken) begin
			btb_tag[wr_idx]    <= resolved.pc[31:IDX_W+2];
			btb_target[wr_idx] <= resolved.target;
		end
	end

endmodule

//--- logic/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

	typedef logic [31:0] virt_t;
	typedef logic [31:0] instr_t;

	// 0 to FETCH_NUM instructions
	typedef logic [$clog2(`FETCH_NUM + 1)-1:0] fetch_cnt_t;

	// request to the instruction cache
	typedef struct packed {
		logic  read;
		virt_t vaddr;
		// drop the response to this request
		logic  flush;
	} fetch_req_t;

	// response, one cycle after the request was accepted
	typedef struct packed {
		logic                          stall;
		instr_t [`FETCH_NUM-1:0]       data;
		logic                          iaddr_ex;
	} fetch_res_t;

	// branch outcome from the back end
	typedef struct packed {
		logic  valid;
		logic  mispredict;
		logic  taken;
		virt_t pc;
		virt_t target;
	} branch_resolved_t;

	typedef struct packed {
		logic  taken;
		virt_t target;
	} branch_predict_t;

	// one instruction handed to the back end
	typedef struct packed {
		logic            valid;
		virt_t           vaddr;
		instr_t          instr;
		branch_predict_t predict;
		logic            iaddr_ex;
	} fetch_entry_t;

endpackage

//--- logic/instr_fetch.sv
`timescale 1ns/100ps
`include "fetch_params.svh"

module instr_fetch #(
	parameter fetch_pkg::virt_t RESET_BASE  = `BOOT_VEC,
	parameter int               BTB_SIZE    = `BTB_SIZE_DEF,
	parameter int               QUEUE_DEPTH = `QUEUE_DEPTH_DEF
)(
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       except_valid,
	input  fetch_pkg::virt_t                           except_vec,
	input  fetch_pkg::branch_resolved_t                resolved_branch,
	input  fetch_pkg::fetch_res_t                      icache_res,
	output fetch_pkg::fetch_req_t                      icache_req,
	input  fetch_pkg::fetch_cnt_t                      fetch_ack,
	output fetch_pkg::fetch_entry_t [`FETCH_NUM-1:0]   fetch_entry
);

	import fetch_pkg::*;

	localparam int OFF_W   = $clog2(`FETCH_NUM);
	localparam int ALIGN_W = OFF_W + 2;

	virt_t pc;
	logic  hold_pc;
	logic  redirect;
	virt_t redirect_vaddr;
	logic  queue_full;

	// stage 1/2 register
	logic  stage_valid;
	virt_t stage_vaddr;

	virt_t                              block_vaddr;
	logic            [OFF_W-1:0]        offset;
	logic            [`FETCH_NUM-1:0]   slot_in_range;
	logic            [`FETCH_NUM-1:0]   slot_keep;
	logic            [`FETCH_NUM-1:0]   taken_mask;
	branch_predict_t [`FETCH_NUM-1:0]   predict;
	logic                               predict_valid;
	virt_t                              predict_vaddr;
	fetch_entry_t    [`FETCH_NUM-1:0]   push_entry;
	fetch_cnt_t                         keep_num;
	fetch_cnt_t                         push_num;

	// exception first, then mispredicted branch
	assign redirect = except_valid | (resolved_branch.valid & resolved_branch.mispredict);
	always_comb begin
		if (except_valid) begin
			redirect_vaddr = except_vec;
		end else if (resolved_branch.taken) begin
			redirect_vaddr = resolved_branch.target;
		end else begin
			redirect_vaddr = resolved_branch.pc + virt_t'(4);
		end
	end

	assign hold_pc = icache_res.stall | queue_full;

	assign icache_req.read  = 1'b1;
	assign icache_req.vaddr = {pc[31:ALIGN_W], {ALIGN_W{1'b0}}};
	assign icache_req.flush = redirect;

	// request in flight during a taken prediction is wrong path
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stage_valid <= 1'b0;
		end else if (redirect) begin
			stage_valid <= 1'b0;
		end else if (!hold_pc) begin
			stage_valid <= ~predict_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold_pc) begin
			stage_vaddr <= pc;
		end
	end

	assign block_vaddr = {stage_vaddr[31:ALIGN_W], {ALIGN_W{1'b0}}};
	assign offset      = stage_vaddr[ALIGN_W-1:2];

	for (genvar i = 0; i < `FETCH_NUM; i++) begin : gen_range
		assign slot_in_range[i] = stage_valid & (i >= offset);
	end

	assign slot_keep = slot_in_range & taken_mask;

	// shift the kept slots down so the push starts at entry 0
	always_comb begin
		int idx;
		keep_num = '0;
		for (int i = 0; i < `FETCH_NUM; i++) begin
			keep_num = keep_num + fetch_cnt_t'(slot_keep[i]);
		end
		for (int k = 0; k < `FETCH_NUM; k++) begin
			idx           = int'(offset) + k;
			push_entry[k] = '0;
			if (idx < `FETCH_NUM) begin
				push_entry[k].valid    = slot_keep[idx];
				push_entry[k].vaddr    = block_vaddr + virt_t'(4 * idx);
				push_entry[k].instr    = icache_res.data[idx];
				push_entry[k].predict  = predict[idx];
				push_entry[k].iaddr_ex = icache_res.iaddr_ex;
			end
		end
	end

	assign push_num = (stage_valid & ~hold_pc & ~redirect) ? keep_num : '0;

	pc_generator #(
		.RESET_BASE ( RESET_BASE )
	) pc_gen_i (
		.clk,
		.rst,
		.hold_pc,
		.redirect,
		.redirect_vaddr,
		.predict_valid,
		.predict_vaddr,
		.pc
	);

	branch_predictor #(
		.BTB_SIZE ( BTB_SIZE )
	) bp_i (
		.clk,
		.rst,
		.block_vaddr,
		.slot_valid    ( slot_in_range   ),
		.resolved      ( resolved_branch ),
		.predict,
		.predict_valid,
		.predict_vaddr,
		.taken_mask
	);

	instr_queue #(
		.QUEUE_DEPTH ( QUEUE_DEPTH )
	) queue_i (
		.clk,
		.rst,
		.flush       ( redirect   ),
		.push_num,
		.push_entry,
		.ack         ( fetch_ack  ),
		.full        ( queue_full ),
		.fetch_entry
	);

endmodule

//--- logic/instr_queue.sv
`timescale 1ns/100ps
`include "fetch_params.svh"

module instr_queue #(
	parameter int QUEUE_DEPTH = `QUEUE_DEPTH_DEF
)(
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       flush,
	input  fetch_pkg::fetch_cnt_t                      push_num,
	input  fetch_pkg::fetch_entry_t [`FETCH_NUM-1:0]   push_entry,
	input  fetch_pkg::fetch_cnt_t                      ack,
	output logic                                       full,
	output fetch_pkg::fetch_entry_t [`FETCH_NUM-1:0]   fetch_entry
);

	import fetch_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	fetch_entry_t mem [QUEUE_DEPTH];

	ptr_t       rd_ptr;
	ptr_t       wr_ptr;
	cnt_t       count;
	fetch_cnt_t out_num;

	// wrap works for any depth
	function automatic ptr_t ptr_add(input ptr_t p, input int n);
		return ptr_t'((int'(p) + n) % QUEUE_DEPTH);
	endfunction

	// a whole fetch block must fit
	assign full = (cnt_t'(QUEUE_DEPTH) - count) < cnt_t'(`FETCH_NUM);

	always_comb begin
		if (count >= cnt_t'(`FETCH_NUM)) begin
			out_num = fetch_cnt_t'(`FETCH_NUM);
		end else begin
			out_num = fetch_cnt_t'(count);
		end
	end

	// oldest entries first, valid bits are leading ones
	always_comb begin
		for (int i = 0; i < `FETCH_NUM; i++) begin
			fetch_entry[i]       = mem[ptr_add(rd_ptr, i)];
			fetch_entry[i].valid = (i < out_num);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= ptr_add(wr_ptr, int'(push_num));
			rd_ptr <= ptr_add(rd_ptr, int'(ack));
			count  <= count + cnt_t'(push_num) - cnt_t'(ack);
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `FETCH_NUM; i++) begin
			if (i < push_num) begin
				mem[ptr_add(wr_ptr, i)] <= push_entry[i];
			end
		end
	end

	// the fetch stage must hold back while full
	assert property (@(posedge clk) disable iff (rst) full |-> push_num == '0)
		else $error("push of %0d entries into a full queue", push_num);

	// back end pops only what it was shown
	assert property (@(posedge clk) disable iff (rst) ack <= out_num)
		else $error("ack %0d exceeds %0d valid entries", ack, out_num);

endmodule

//--- logic/pc_generator.sv
`timescale 1ns/100ps
`include "fetch_params.svh"

module pc_generator #(
	parameter fetch_pkg::virt_t RESET_BASE = `BOOT_VEC
)(
	input  logic             clk,
	input  logic             rst,
	input  logic             hold_pc,
	input  logic             redirect,
	input  fetch_pkg::virt_t redirect_vaddr,
	input  logic             predict_valid,
	input  fetch_pkg::virt_t predict_vaddr,
	output fetch_pkg::virt_t pc
);

	import fetch_pkg::*;

	localparam int ALIGN_W = $clog2(`FETCH_NUM) + 2;

	virt_t pc_next;
	virt_t pc_aligned;

	assign pc_aligned = {pc[31:ALIGN_W], {ALIGN_W{1'b0}}};

	// redirect wins even over a stalled cache or a full queue
	always_comb begin
		if (redirect) begin
			pc_next = redirect_vaddr;
		end else if (hold_pc) begin
			pc_next = pc;
		end else if (predict_valid) begin
			pc_next = predict_vaddr;
		end else begin
			pc_next = pc_aligned + virt_t'(`FETCH_NUM * 4);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= RESET_BASE;
		end else begin
			pc <= pc_next;
		end
	end

	// redirect and predicted targets must stay word aligned
	assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else $error("fetch address %h is not word aligned", pc);

endmodule

//--- testbench/tb_instr_fetch.sv
`timescale 1ns/100ps
`include "fetch_params.svh"

module tb_instr_fetch;

	import fetch_pkg::*;

	localparam int     BTB_SIZE       = `BTB_SIZE_DEF;
	localparam instr_t WORD_MASK      = 32'h5a5a5a5a;
	localparam int     TARGET_POPS    = 1200;
	// rough length of the run with stalls, redirects and idle windows
	localparam int     STIM_CYCLES    = 2400;
	localparam int     TIMEOUT_CYCLES = 4 * STIM_CYCLES;

	logic                          clk = 1'b0;
	logic                          rst;
	logic                          except_valid;
	virt_t                         except_vec;
	branch_resolved_t              resolved_branch;
	fetch_res_t                    icache_res;
	fetch_req_t                    icache_req;
	fetch_cnt_t                    fetch_ack;
	fetch_entry_t [`FETCH_NUM-1:0] fetch_entry;

	integer seed = 98836;
	int     checks = 0;
	int     errors = 0;
	int     pops = 0;
	int     redirects = 0;
	int     taken_seen = 0;
	int     fault_seen = 0;

	// back-end model
	virt_t exp_pc;
	virt_t last_pop;
	logic  have_pop;
	virt_t trained_pc;
	logic  trained;
	logic  btb_valid_m  [BTB_SIZE];
	virt_t btb_pc_m     [BTB_SIZE];
	virt_t btb_target_m [BTB_SIZE];

	// cache model
	virt_t resp_addr;
	logic  req_taken;
	virt_t req_vaddr;

	instr_fetch #(
		.RESET_BASE  ( `BOOT_VEC        ),
		.BTB_SIZE    ( BTB_SIZE         ),
		.QUEUE_DEPTH ( `QUEUE_DEPTH_DEF )
	) instr_fetch_i (
		.clk,
		.rst,
		.except_valid,
		.except_vec,
		.resolved_branch,
		.icache_res,
		.icache_req,
		.fetch_ack,
		.fetch_entry
	);

	always #10 clk = ~clk;

	// the fetch unit takes a response only in cycles where it does not hold
	always @(negedge clk) begin
		req_taken <= ~instr_fetch_i.hold_pc;
		req_vaddr <= icache_req.vaddr;
	end

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic virt_t block_of(input virt_t a);
		return a & ~virt_t'(`FETCH_NUM * 4 - 1);
	endfunction

	// word address in a 1 KB window, so trained branches get revisited
	function automatic virt_t rand_addr(input logic [7:0] top);
		return {top, 24'hc00000} + virt_t'(rand_below(256) * 4);
	endfunction

	function automatic int btb_index(input virt_t a);
		return int'((a >> 2) % BTB_SIZE);
	endfunction

	function automatic branch_predict_t predict_of(input virt_t a);
		int              idx;
		branch_predict_t p;
		idx      = btb_index(a);
		p.taken  = btb_valid_m[idx] && (btb_pc_m[idx] == a);
		p.target = p.taken ? btb_target_m[idx] : a + 4;
		return p;
	endfunction

	task automatic check_vaddr(input string name, input virt_t got, input virt_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_instr(input string name, input instr_t got, input instr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_predict(input string name, input branch_predict_t got,
			input branch_predict_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got taken %h target %h expected taken %h target %h",
				name, got.taken, got.target, exp.taken, exp.target);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	// answers the request accepted at the last edge
	task automatic drive_cache();
		if (req_taken) begin
			resp_addr = req_vaddr;
		end
		// stall one cycle in four
		icache_res.stall = (rand_below(4) == 0);
		for (int i = 0; i < `FETCH_NUM; i++) begin
			icache_res.data[i] = (resp_addr + virt_t'(4 * i)) ^ WORD_MASK;
		end
		icache_res.iaddr_ex = (resp_addr[31:24] == 8'h7f);
	endtask

	task automatic check_entry(input fetch_entry_t e);
		branch_predict_t p;
		p = predict_of(exp_pc);
		check_vaddr("fetch_entry.vaddr", e.vaddr, exp_pc);
		check_instr("fetch_entry.instr", e.instr, exp_pc ^ WORD_MASK);
		check_flag("fetch_entry.iaddr_ex", e.iaddr_ex, exp_pc[31:24] == 8'h7f);
		check_predict("fetch_entry.predict", e.predict, p);
		taken_seen += int'(p.taken);
		fault_seen += int'(exp_pc[31:24] == 8'h7f);
		last_pop = exp_pc;
		have_pop = 1'b1;
		exp_pc   = p.taken ? p.target : exp_pc + 4;
		pops++;
	endtask

	task automatic pop_entries(input int cyc);
		int nvalid;
		int nack;
		nvalid = 0;
		for (int i = 0; i < `FETCH_NUM; i++) begin
			if (fetch_entry[i].valid && nvalid == i) begin
				nvalid++;
			end
		end
		// idle windows let the queue fill up
		if ((cyc % 64) >= 48) begin
			nack = 0;
		end else begin
			nack = rand_below(nvalid + 1);
		end
		for (int i = 0; i < nack; i++) begin
			check_entry(fetch_entry[i]);
		end
		fetch_ack = fetch_cnt_t'(nack);
	endtask

	// mispredict on the last popped entry, an exception, or both at once
	task automatic make_redirect();
		int    kind;
		int    idx;
		virt_t vec;
		kind = rand_below(8);
		vec  = rand_addr(8'hbf);
		if (kind == 5) begin
			vec = rand_addr(8'h7f);
		end
		if (kind == 6 && trained) begin
			vec = trained_pc;
		end
		if (kind < 4 || kind == 7) begin
			resolved_branch.valid      = 1'b1;
			resolved_branch.mispredict = 1'b1;
			resolved_branch.taken      = rand_below(2) == 1;
			resolved_branch.pc         = last_pop;
			resolved_branch.target     = rand_addr(8'hbf);
			idx                        = btb_index(last_pop);
			btb_valid_m[idx]           = resolved_branch.taken;
			btb_pc_m[idx]              = last_pop;
			btb_target_m[idx]          = resolved_branch.target;
			if (resolved_branch.taken) begin
				trained_pc = last_pop;
				trained    = 1'b1;
				exp_pc     = resolved_branch.target;
			end else begin
				exp_pc = last_pop + 4;
			end
		end
		if (kind >= 4) begin
			except_valid = 1'b1;
			except_vec   = vec;
			exp_pc       = vec;
		end
		redirects++;
		have_pop = 1'b0;
	endtask

	initial begin
		int   cycle;
		logic do_redir;
		logic redir_last;
		rst             = 1'b1;
		except_valid    = 1'b0;
		except_vec      = '0;
		resolved_branch = '0;
		icache_res      = '0;
		fetch_ack       = '0;
		exp_pc          = `BOOT_VEC;
		last_pop        = '0;
		have_pop        = 1'b0;
		trained_pc      = '0;
		trained         = 1'b0;
		resp_addr       = block_of(`BOOT_VEC);
		cycle           = 0;
		redir_last      = 1'b0;
		for (int i = 0; i < BTB_SIZE; i++) begin
			btb_valid_m[i] = 1'b0;
		end

		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		check_vaddr("icache_req.vaddr", icache_req.vaddr, block_of(`BOOT_VEC));
		check_flag("icache_req.flush", icache_req.flush, 1'b0);
		check_flag("icache_req.read", icache_req.read, 1'b1);
		for (int i = 0; i < `FETCH_NUM; i++) begin
			check_flag("fetch_entry.valid", fetch_entry[i].valid, 1'b0);
		end
		drive_cache();

		while (pops < TARGET_POPS && cycle < TIMEOUT_CYCLES) begin
			@(posedge clk);
			#2;
			cycle++;
			drive_cache();
			resolved_branch = '0;
			except_valid    = 1'b0;
			fetch_ack       = '0;
			// queue empty and request at the new block right after a redirect
			if (redir_last) begin
				check_vaddr("icache_req.vaddr", icache_req.vaddr, block_of(exp_pc));
				for (int i = 0; i < `FETCH_NUM; i++) begin
					check_flag("fetch_entry.valid", fetch_entry[i].valid, 1'b0);
				end
			end
			// plain sequential fetch for the first cycles
			do_redir = have_pop && cycle > 100 && rand_below(16) == 0;
			if (do_redir) begin
				make_redirect();
			end else begin
				pop_entries(cycle);
			end
			redir_last = do_redir;
			#5;
			check_flag("icache_req.flush", icache_req.flush, do_redir);
			check_flag("icache_req.read", icache_req.read, 1'b1);
		end

		if (pops < TARGET_POPS) begin
			errors++;
			$display("timeout after %0d cycles with only %0d of %0d entries popped",
				cycle, pops, TARGET_POPS);
		end
		if (taken_seen == 0) begin
			errors++;
			$display("no popped entry carried a taken prediction");
		end
		if (fault_seen == 0) begin
			errors++;
			$display("no entry from the fault region was popped");
		end
		$display("%0d checks, %0d errors, %0d pops, %0d redirects, %0d predicted taken",
			checks, errors, pops, redirects, taken_seen);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
